// File: hw/icache_pkg.sv
package icache_pkg;

	// ========================================
	// Cache geometry
	// ========================================

	// Byte address width of a fetch
	localparam int ADDR_W = 16;

	// Bytes held by one cache line
	localparam int LINE_BYTES = 8;

	// Sets in each of the two banks
	localparam int SETS = 16;

	// Associativity of each bank
	localparam int WAYS = 2;

	// Response queue entries and the fetch credits owned by the requester after reset
	localparam int RESP_DEPTH = 4;

	// ========================================
	// Derived address layout
	// ========================================

	// Byte offset inside a line
	localparam int OFFSET_W = $clog2(LINE_BYTES);

	// The lowest line-address bit picks the even or odd bank
	localparam int BANK_BIT = OFFSET_W;

	// Set index sits right above the bank bit
	localparam int INDEX_W   = $clog2(SETS);
	localparam int INDEX_LSB = BANK_BIT + 1;

	// Whatever is left above the index forms the tag
	localparam int TAG_LSB = INDEX_LSB + INDEX_W;
	localparam int TAG_W   = ADDR_W - TAG_LSB;

	// A line address is the byte address without its offset
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	localparam int LINE_W = LINE_BYTES * 8;
	localparam int WAY_W  = $clog2(WAYS);

	// Queue pointer and occupancy counter widths
	localparam int PTR_W = $clog2(RESP_DEPTH);
	localparam int CNT_W = $clog2(RESP_DEPTH + 1);

	// ========================================
	// Types
	// ========================================

	typedef logic [ADDR_W-1:0]   fetch_addr_t;
	typedef logic [LINE_W-1:0]   line_data_t;

	// Upper half carries the line after the addressed one
	typedef logic [2*LINE_W-1:0] window_t;

	typedef logic [INDEX_W-1:0]  set_index_t;
	typedef logic [TAG_W-1:0]    line_tag_t;
	typedef logic [WAY_W-1:0]    way_t;

endpackage

// File: hw/icache_lookup_if.sv
`timescale 1ns/100ps

interface icache_lookup_if import icache_pkg::*; ();

	// One decoded lookup travels to both banks at once
	logic        valid;
	fetch_addr_t addr;

	// Each bank gets its own index and tag since the next line may wrap into a new tag
	set_index_t  even_index;
	set_index_t  odd_index;
	line_tag_t   even_tag;
	line_tag_t   odd_tag;

	// The decode stage produces every field
	modport decode_mp (
		output valid, addr, even_index, odd_index, even_tag, odd_tag
	);

	// A bank picks the index and tag for its own half
	modport bank_mp (
		input valid, even_index, odd_index, even_tag, odd_tag
	);

	// The response side needs only the request and its address
	modport result_mp (
		input valid, addr
	);

endinterface

// File: hw/icache_fetch_decode.sv
`timescale 1ns/100ps

module icache_fetch_decode import icache_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        fetch_valid_i,
	input  fetch_addr_t fetch_addr_i,
	icache_lookup_if.decode_mp lookup
);

	// ========================================
	// Line address split
	// ========================================

	// Line holding the fetch address and the one right after it
	logic [LINE_ADDR_W-1:0] line_cur;
	logic [LINE_ADDR_W-1:0] line_nxt;

	// The same two lines sorted by the bank that stores them
	logic [LINE_ADDR_W-1:0] line_even;
	logic [LINE_ADDR_W-1:0] line_odd;

	assign line_cur = fetch_addr_i[ADDR_W-1:OFFSET_W];

	// Carry out of the set index runs on into the tag
	assign line_nxt = line_cur + 1'b1;

	always_comb begin
		// An even line is followed by an odd one and the reverse
		if (line_cur[0] == 1'b0) begin
			line_even = line_cur;
			line_odd  = line_nxt;
		end else begin
			line_even = line_nxt;
			line_odd  = line_cur;
		end
	end

	// ========================================
	// Request register
	// ========================================

	// Only the request flag is control state
	always_ff @(posedge clk) begin
		if (reset_i) begin
			lookup.valid <= 1'b0;
		end else begin
			lookup.valid <= fetch_valid_i;
		end
	end

	// Address fields are loaded only with a request so they stay stable otherwise
	always_ff @(posedge clk) begin
		if (fetch_valid_i) begin
			lookup.addr <= fetch_addr_i;

			// Line address bit 0 is the bank select and is dropped here
			lookup.even_index <= line_even[INDEX_W:1];
			lookup.odd_index  <= line_odd[INDEX_W:1];
			lookup.even_tag   <= line_even[LINE_ADDR_W-1:INDEX_W+1];
			lookup.odd_tag    <= line_odd[LINE_ADDR_W-1:INDEX_W+1];
		end
	end

endmodule

// File: hw/icache_bank.sv
`timescale 1ns/100ps

module icache_bank import icache_pkg::*; #(
	// Line-address parity served by this bank
	parameter bit BANK_ODD = 1'b0
) (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        refill_valid_i,
	input  fetch_addr_t refill_addr_i,
	input  line_data_t  refill_data_i,
	input  logic        snoop_valid_i,
	input  fetch_addr_t snoop_addr_i,
	input  logic        invall_i,
	icache_lookup_if.bank_mp lookup,
	output logic        hit_o,
	output line_data_t  line_o
);

	// ========================================
	// Storage
	// ========================================

	line_tag_t       tag_q      [WAYS][SETS];
	line_data_t      data_q     [WAYS][SETS];
	logic [SETS-1:0] valid_q    [WAYS];

	// Next way to fill in each set
	way_t            fill_ptr_q [SETS];

	// Lookup side
	set_index_t      look_index;
	line_tag_t       look_tag;
	logic            look_hit;
	way_t            look_way;

	// Refill side
	logic            refill_en;
	set_index_t      refill_index;
	line_tag_t       refill_tag;
	way_t            victim;
	logic [WAYS-1:0] refill_stale;

	// Snoop side
	logic            snoop_en;
	set_index_t      snoop_index;
	line_tag_t       snoop_tag;
	logic [WAYS-1:0] snoop_match;

	// Lookup uses the half of the decoded request that belongs to this bank
	assign look_index = BANK_ODD ? lookup.odd_index : lookup.even_index;
	assign look_tag   = BANK_ODD ? lookup.odd_tag : lookup.even_tag;

	// Refills and snoops for the other bank are ignored
	assign refill_en    = refill_valid_i && (refill_addr_i[BANK_BIT] == BANK_ODD);
	assign refill_index = refill_addr_i[INDEX_LSB +: INDEX_W];
	assign refill_tag   = refill_addr_i[TAG_LSB +: TAG_W];
	assign victim       = fill_ptr_q[refill_index];

	assign snoop_en    = snoop_valid_i && (snoop_addr_i[BANK_BIT] == BANK_ODD);
	assign snoop_index = snoop_addr_i[INDEX_LSB +: INDEX_W];
	assign snoop_tag   = snoop_addr_i[TAG_LSB +: TAG_W];

	// ========================================
	// Way compare
	// ========================================

	always_comb begin
		look_hit = 1'b0;
		look_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[w][look_index] && tag_q[w][look_index] == look_tag) begin
				look_hit = 1'b1;
				look_way = way_t'(w);
			end
		end
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			// A resident copy outside the victim way would become a duplicate
			refill_stale[w] = valid_q[w][refill_index] &&
				tag_q[w][refill_index] == refill_tag && way_t'(w) != victim;
			snoop_match[w] = valid_q[w][snoop_index] && tag_q[w][snoop_index] == snoop_tag;
		end
	end

	// ========================================
	// Valid bits and fill pointers
	// ========================================

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
			end
			for (int s = 0; s < SETS; s++) begin
				fill_ptr_q[s] <= '0;
			end
		end else begin
			if (refill_en) begin
				valid_q[victim][refill_index] <= 1'b1;
				fill_ptr_q[refill_index]      <= victim + way_t'(1);
				// Drop the older copy of a line that is refilled again
				for (int w = 0; w < WAYS; w++) begin
					if (refill_stale[w]) begin
						valid_q[w][refill_index] <= 1'b0;
					end
				end
			end
			// A snoop wins over a refill to the same entry
			if (snoop_en) begin
				for (int w = 0; w < WAYS; w++) begin
					if (snoop_match[w]) begin
						valid_q[w][snoop_index] <= 1'b0;
					end
				end
			end
			// Invalidate-all leaves the fill pointers where they are
			if (invall_i) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[w] <= '0;
				end
			end
		end
	end

	// Tag and line arrays are plain memory
	always_ff @(posedge clk) begin
		if (refill_en) begin
			tag_q[victim][refill_index]  <= refill_tag;
			data_q[victim][refill_index] <= refill_data_i;
		end
	end

	// ========================================
	// Result register
	// ========================================

	always_ff @(posedge clk) begin
		if (reset_i) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= lookup.valid && look_hit;
		end
	end

	always_ff @(posedge clk) begin
		line_o <= data_q[look_way][look_index];
	end

	// True when two valid ways of a set carry the same tag
	function automatic logic set_has_duplicate(set_index_t s);
		logic dup;
		dup = 1'b0;
		for (int i = 0; i < WAYS; i++) begin
			for (int j = i + 1; j < WAYS; j++) begin
				if (valid_q[i][s] && valid_q[j][s] && tag_q[i][s] == tag_q[j][s]) begin
					dup = 1'b1;
				end
			end
		end
		return dup;
	endfunction

	// Only a refill can create a duplicate so the set it wrote is checked one cycle later
	a_no_dup_tag: assert property (@(posedge clk) disable iff (reset_i)
		refill_en |=> !set_has_duplicate($past(refill_index)))
		else $error("bank %0d holds a duplicate tag", BANK_ODD);

endmodule

// File: hw/icache_resp_queue.sv
`timescale 1ns/100ps

module icache_resp_queue import icache_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        even_hit_i,
	input  logic        odd_hit_i,
	input  line_data_t  even_line_i,
	input  line_data_t  odd_line_i,
	input  logic        resp_credit_i,
	icache_lookup_if.result_mp lookup,
	output logic        resp_valid_o,
	output logic        resp_hit_o,
	output fetch_addr_t resp_addr_o,
	output window_t     resp_window_o,
	output logic        fetch_credit_o
);

	// Request flag and address aligned with the registered bank outputs
	logic        look_valid_q;
	fetch_addr_t look_addr_q;

	logic        enq;
	logic        deq;
	logic        enq_hit;
	window_t     enq_window;

	// Queue storage
	logic        hit_mem    [RESP_DEPTH];
	fetch_addr_t addr_mem   [RESP_DEPTH];
	window_t     window_mem [RESP_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	// Response slots granted by the consumer and not yet used
	logic [CNT_W-1:0] credit_q;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(RESP_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ========================================
	// Bank alignment and window order
	// ========================================

	always_ff @(posedge clk) begin
		if (reset_i) begin
			look_valid_q <= 1'b0;
		end else begin
			look_valid_q <= lookup.valid;
		end
	end

	always_ff @(posedge clk) begin
		look_addr_q <= lookup.addr;
	end

	assign enq = look_valid_q;

	// Both lines must be present for the window to count as a hit
	assign enq_hit = even_hit_i & odd_hit_i;

	// Addressed line in the low half and the following line above it
	assign enq_window = look_addr_q[BANK_BIT] ? {even_line_i, odd_line_i}
		: {odd_line_i, even_line_i};

	// ========================================
	// Queue and credits
	// ========================================

	// A response leaves only against a consumer credit
	assign deq = (count_q != '0) && (credit_q != '0);

	always_ff @(posedge clk) begin
		if (enq) begin
			hit_mem[wr_ptr_q]    <= enq_hit;
			addr_mem[wr_ptr_q]   <= look_addr_q;
			window_mem[wr_ptr_q] <= enq_window;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= '0;
		end else begin
			if (enq) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (deq) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({enq, deq})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			case ({resp_credit_i, deq})
				2'b10: credit_q <= credit_q + 1'b1;
				2'b01: credit_q <= credit_q - 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	// Each delivered response frees a slot and hands a fetch credit back
	assign resp_valid_o   = deq;
	assign fetch_credit_o = deq;
	assign resp_hit_o     = hit_mem[rd_ptr_q];
	assign resp_addr_o    = addr_mem[rd_ptr_q];
	assign resp_window_o  = window_mem[rd_ptr_q];

	// The requester credit limit keeps the pipeline from pushing into a full queue
	a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
		enq |-> count_q != CNT_W'(RESP_DEPTH))
		else $error("response queue overflow");

	// The consumer never grants more slots than the queue holds
	a_credit_bound: assert property (@(posedge clk) disable iff (reset_i)
		credit_q <= CNT_W'(RESP_DEPTH))
		else $error("consumer credit count above queue depth");

endmodule

// File: hw/icache_top.sv
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,

	// Fetch requests
	input  logic        fetch_valid_i,
	input  fetch_addr_t fetch_addr_i,
	output logic        fetch_credit_o,

	// Responses
	output logic        resp_valid_o,
	output logic        resp_hit_o,
	output fetch_addr_t resp_addr_o,
	output window_t     resp_window_o,
	input  logic        resp_credit_i,

	// Line refill
	input  logic        refill_valid_i,
	input  fetch_addr_t refill_addr_i,
	input  line_data_t  refill_data_i,

	// Invalidation
	input  logic        snoop_valid_i,
	input  fetch_addr_t snoop_addr_i,
	input  logic        invall_i
);

	// Bank results one cycle after the lookup
	logic       even_hit;
	logic       odd_hit;
	line_data_t even_line;
	line_data_t odd_line;

	// ========================================
	// Decode feeds both banks and the queue
	// ========================================

	icache_lookup_if lookup_bus ();

	icache_fetch_decode u_decode (
		.clk           (clk),
		.reset_i       (reset_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_addr_i  (fetch_addr_i),
		.lookup        (lookup_bus.decode_mp)
	);

	// Even-numbered lines
	icache_bank #(.BANK_ODD(1'b0)) u_bank_even (
		.clk            (clk),
		.reset_i        (reset_i),
		.refill_valid_i (refill_valid_i),
		.refill_addr_i  (refill_addr_i),
		.refill_data_i  (refill_data_i),
		.snoop_valid_i  (snoop_valid_i),
		.snoop_addr_i   (snoop_addr_i),
		.invall_i       (invall_i),
		.lookup         (lookup_bus.bank_mp),
		.hit_o          (even_hit),
		.line_o         (even_line)
	);

	// Odd-numbered lines
	icache_bank #(.BANK_ODD(1'b1)) u_bank_odd (
		.clk            (clk),
		.reset_i        (reset_i),
		.refill_valid_i (refill_valid_i),
		.refill_addr_i  (refill_addr_i),
		.refill_data_i  (refill_data_i),
		.snoop_valid_i  (snoop_valid_i),
		.snoop_addr_i   (snoop_addr_i),
		.invall_i       (invall_i),
		.lookup         (lookup_bus.bank_mp),
		.hit_o          (odd_hit),
		.line_o         (odd_line)
	);

	icache_resp_queue u_resp_queue (
		.clk            (clk),
		.reset_i        (reset_i),
		.even_hit_i     (even_hit),
		.odd_hit_i      (odd_hit),
		.even_line_i    (even_line),
		.odd_line_i     (odd_line),
		.resp_credit_i  (resp_credit_i),
		.lookup         (lookup_bus.result_mp),
		.resp_valid_o   (resp_valid_o),
		.resp_hit_o     (resp_hit_o),
		.resp_addr_o    (resp_addr_o),
		.resp_window_o  (resp_window_o),
		.fetch_credit_o (fetch_credit_o)
	);

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	// Full clock period in ns
	parameter real PERIOD_NS = 40.0
) (
	output logic clk
);

	// Free-running clock that starts low
	initial begin
		clk = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2.0);
		clk = ~clk;
	end

endmodule

// File: tests/icache_tb.sv
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// Longest wait in cycles for any handshake
	localparam int WAIT_LIMIT = 200;

	logic        clk;
	logic        reset_i;
	logic        fetch_valid_i;
	fetch_addr_t fetch_addr_i;
	logic        fetch_credit_o;
	logic        resp_valid_o;
	logic        resp_hit_o;
	fetch_addr_t resp_addr_o;
	window_t     resp_window_o;
	logic        resp_credit_i;
	logic        refill_valid_i;
	fetch_addr_t refill_addr_i;
	line_data_t  refill_data_i;
	logic        snoop_valid_i;
	fetch_addr_t snoop_addr_i;
	logic        invall_i;

	// Reference cache state per bank, set and way
	line_addr_t  m_line  [2][SETS][WAYS];
	logic        m_valid [2][SETS][WAYS];
	int          m_ptr   [2][SETS];

	// Expected responses in request order
	fetch_addr_t exp_addr_q [$];
	logic        exp_hit_q  [$];
	window_t     exp_win_q  [$];

	// Credit models and counters
	int          req_credits;
	int          cons_credits;
	int          resp_count;
	int          pulse_count;
	logic [31:0] rng;

	tb_clock_gen #(.PERIOD_NS(40.0)) u_clk (.clk(clk));

	icache_top uut (
		.clk            (clk),
		.reset_i        (reset_i),
		.fetch_valid_i  (fetch_valid_i),
		.fetch_addr_i   (fetch_addr_i),
		.fetch_credit_o (fetch_credit_o),
		.resp_valid_o   (resp_valid_o),
		.resp_hit_o     (resp_hit_o),
		.resp_addr_o    (resp_addr_o),
		.resp_window_o  (resp_window_o),
		.resp_credit_i  (resp_credit_i),
		.refill_valid_i (refill_valid_i),
		.refill_addr_i  (refill_addr_i),
		.refill_data_i  (refill_data_i),
		.snoop_valid_i  (snoop_valid_i),
		.snoop_addr_i   (snoop_addr_i),
		.invall_i       (invall_i)
	);

	// ========================================
	// Reference functions
	// ========================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Every field of the line depends on the whole line address
	function automatic line_data_t line_content(input line_addr_t l);
		logic [15:0] x;
		x = 16'(l);
		return {x ^ 16'hc3a5, x * 16'd41 + 16'h001f, ~x, x + 16'h7e01};
	endfunction

	function automatic logic line_cached(input line_addr_t l);
		logic found;
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[l[0]][l[INDEX_W:1]][w] && m_line[l[0]][l[INDEX_W:1]][w] == l) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// A window hits only when the addressed line and the one after it are both present
	function automatic logic window_hit(input fetch_addr_t a);
		line_addr_t l;
		l = a[ADDR_W-1:OFFSET_W];
		return line_cached(l) && line_cached(l + 1'b1);
	endfunction

	function automatic window_t window_data(input fetch_addr_t a);
		line_addr_t l;
		l = a[ADDR_W-1:OFFSET_W];
		return {line_content(l + 1'b1), line_content(l)};
	endfunction

	// ========================================
	// Reporting and compare tasks
	// ========================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_addr(input string name, input fetch_addr_t got, input fetch_addr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_window(input string name, input window_t got, input window_t exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_hit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	// ========================================
	// Reference model updates
	// ========================================

	// Victim comes from the fill pointer and an older copy in the other way is dropped
	task automatic model_refill(input line_addr_t l);
		int b;
		int s;
		int v;
		b = l[0];
		s = l[INDEX_W:1];
		v = m_ptr[b][s];
		for (int w = 0; w < WAYS; w++) begin
			if (w != v && m_valid[b][s][w] && m_line[b][s][w] == l) begin
				m_valid[b][s][w] = 1'b0;
			end
		end
		m_line[b][s][v]  = l;
		m_valid[b][s][v] = 1'b1;
		m_ptr[b][s]      = (v + 1) % WAYS;
	endtask

	task automatic model_snoop(input line_addr_t l);
		for (int w = 0; w < WAYS; w++) begin
			if (m_line[l[0]][l[INDEX_W:1]][w] == l) begin
				m_valid[l[0]][l[INDEX_W:1]][w] = 1'b0;
			end
		end
	endtask

	// ========================================
	// Stimulus tasks
	// ========================================

	// Single-cycle pulses drop back at the next edge
	task automatic clear_inputs();
		fetch_valid_i  <= 1'b0;
		resp_credit_i  <= 1'b0;
		refill_valid_i <= 1'b0;
		snoop_valid_i  <= 1'b0;
		invall_i       <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			clear_inputs();
		end
	endtask

	// The consumer never grants more slots than the queue holds
	task automatic offer_credit();
		if (cons_credits < RESP_DEPTH) begin
			resp_credit_i <= 1'b1;
			cons_credits++;
		end
	endtask

	task automatic refill_line(input line_addr_t l);
		@(posedge clk);
		clear_inputs();
		refill_valid_i <= 1'b1;
		refill_addr_i  <= {l, 3'd5};
		refill_data_i  <= line_content(l);
		model_refill(l);
	endtask

	task automatic snoop_line(input line_addr_t l);
		@(posedge clk);
		clear_inputs();
		snoop_valid_i <= 1'b1;
		snoop_addr_i  <= {l, 3'd2};
		model_snoop(l);
	endtask

	task automatic invalidate_all();
		@(posedge clk);
		clear_inputs();
		invall_i <= 1'b1;
		for (int b = 0; b < 2; b++) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					m_valid[b][s][w] = 1'b0;
				end
			end
		end
	endtask

	// Waits for a fetch credit and records the expected result at request time
	task automatic issue_fetch(input fetch_addr_t a, input logic grant_ok);
		int waited;
		logic sent;
		waited = 0;
		sent = 1'b0;
		while (!sent) begin
			@(posedge clk);
			clear_inputs();
			if (grant_ok || waited > 0) begin
				offer_credit();
			end
			if (req_credits > 0) begin
				fetch_valid_i <= 1'b1;
				fetch_addr_i  <= a;
				req_credits--;
				exp_addr_q.push_back(a);
				exp_hit_q.push_back(window_hit(a));
				exp_win_q.push_back(window_data(a));
				sent = 1'b1;
			end else begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					fail_run("Timed out waiting for a fetch credit");
				end
			end
		end
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		while (exp_addr_q.size() != 0) begin
			@(posedge clk);
			clear_inputs();
			if (cons_credits < exp_addr_q.size()) begin
				offer_credit();
			end
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("Timed out waiting for outstanding responses");
			end
		end
	endtask

	// Miss first, then refill both lines of the window and hit
	task automatic window_case(input line_addr_t l);
		issue_fetch({l, 3'd6}, 1'b0);
		drain_responses();
		refill_line(l);
		refill_line(l + 1'b1);
		idle_cycles(1);
		issue_fetch({l, 3'd1}, 1'b0);
		drain_responses();
	endtask

	// ========================================
	// Response comparison
	// ========================================

	// Outputs are sampled mid-cycle where they are stable
	always @(negedge clk) begin : compare_responses
		fetch_addr_t e_addr;
		logic        e_hit;
		window_t     e_win;
		if (!reset_i) begin
			if (fetch_credit_o) begin
				req_credits++;
				pulse_count++;
				if (req_credits > RESP_DEPTH) begin
					fail_run("More fetch credits returned than were spent");
				end
			end
			if (resp_valid_o) begin
				if (exp_addr_q.size() == 0) begin
					fail_run("Response delivered with no request outstanding");
				end
				if (cons_credits == 0) begin
					fail_run("Response delivered without a consumer credit");
				end
				e_addr = exp_addr_q.pop_front();
				e_hit  = exp_hit_q.pop_front();
				e_win  = exp_win_q.pop_front();
				check_addr("resp_addr_o", resp_addr_o, e_addr);
				check_hit("resp_hit_o", resp_hit_o, e_hit);
				// Line data is only defined for a hit
				if (e_hit) begin
					check_window("resp_window_o", resp_window_o, e_win);
				end
				resp_count++;
				cons_credits--;
			end
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin : main_flow
		int n;
		int resp_before;
		int pulse_before;
		fetch_addr_t a;
		line_addr_t l;
		reset_i        = 1'b1;
		fetch_valid_i  = 1'b0;
		fetch_addr_i   = '0;
		resp_credit_i  = 1'b0;
		refill_valid_i = 1'b0;
		refill_addr_i  = '0;
		refill_data_i  = '0;
		snoop_valid_i  = 1'b0;
		snoop_addr_i   = '0;
		invall_i       = 1'b0;
		req_credits    = RESP_DEPTH;
		cons_credits   = 0;
		resp_count     = 0;
		pulse_count    = 0;
		rng            = 32'hc59ff802;
		for (int b = 0; b < 2; b++) begin
			for (int s = 0; s < SETS; s++) begin
				m_ptr[b][s] = 0;
				for (int w = 0; w < WAYS; w++) begin
					m_valid[b][s][w] = 1'b0;
					m_line[b][s][w]  = '0;
				end
			end
		end
		repeat (5) @(posedge clk);
		reset_i <= 1'b0;
		idle_cycles(2);

		// Even line, odd line and an odd line at set 15 whose successor carries into the tag
		window_case(13'h0024);
		window_case(13'h0047);
		window_case(13'h003f);

		// Three lines share set 5 of each bank so the third refill evicts the first
		for (int i = 0; i < 3; i++) begin
			refill_line(13'h010a + line_addr_t'(i * 32));
			refill_line(13'h010b + line_addr_t'(i * 32));
		end
		idle_cycles(1);
		for (int i = 0; i < 3; i++) begin
			issue_fetch({13'h010a + line_addr_t'(i * 32), 3'd0}, 1'b0);
		end
		drain_responses();

		// A snooped line misses in every window that holds it
		snoop_line(13'h012b);
		idle_cycles(1);
		issue_fetch({13'h012a, 3'd4}, 1'b0);
		issue_fetch({13'h012b, 3'd0}, 1'b0);
		issue_fetch({13'h014a, 3'd7}, 1'b0);
		issue_fetch({13'h0047, 3'd3}, 1'b0);
		drain_responses();
		invalidate_all();
		idle_cycles(1);
		issue_fetch({13'h0024, 3'd0}, 1'b0);
		issue_fetch({13'h014a, 3'd0}, 1'b0);
		issue_fetch({13'h0047, 3'd0}, 1'b0);
		drain_responses();

		// Without consumer credits the queue fills and holds every response
		for (int i = 0; i < RESP_DEPTH; i++) begin
			issue_fetch({13'h0300 + line_addr_t'(i), 3'd0}, 1'b0);
		end
		resp_before  = resp_count;
		pulse_before = pulse_count;
		idle_cycles(10);
		if (resp_count != resp_before || pulse_count != pulse_before) begin
			fail_run("Response or fetch credit appeared while no consumer credit was held");
		end
		drain_responses();

		// With a held credit and an empty queue the latency is fixed
		@(posedge clk);
		clear_inputs();
		offer_credit();
		idle_cycles(3);
		issue_fetch({13'h0024, 3'd0}, 1'b0);
		n = 0;
		while (1) begin
			@(negedge clk);
			n++;
			if (resp_valid_o) begin
				break;
			end
			if (n > WAIT_LIMIT) begin
				fail_run("Timed out waiting for the fixed-latency response");
			end
			idle_cycles(1);
		end
		// The request is sampled one edge after it is driven and shows at the fourth falling edge
		if (n != 4) begin
			fail_run($sformatf("MISMATCH at %0t: response latency got %0d expected %0d",
				$time, n, 4));
		end
		check_hit("fetch_credit_o", fetch_credit_o, 1'b1);

		// Random refills over three tags per set followed by random traffic
		for (int i = 0; i < 40; i++) begin
			rng = lcg_next(rng);
			refill_line(line_addr_t'(13'h0200 + (rng[23:16] % 96)));
		end
		idle_cycles(1);
		for (int i = 0; i < 60; i++) begin
			rng = lcg_next(rng);
			l = line_addr_t'(13'h0200 + (rng[23:16] % 96));
			a = {l, rng[10:8]};
			issue_fetch(a, rng[31]);
		end
		drain_responses();
		idle_cycles(2);
		if (pulse_count != resp_count) begin
			fail_run($sformatf("MISMATCH at %0t: fetch_credit_o pulses got %0d expected %0d",
				$time, pulse_count, resp_count));
		end

		$display("All checks passed");
		$finish;
	end

endmodule

// File: src.f
hw/icache_pkg.sv
hw/icache_lookup_if.sv
hw/icache_fetch_decode.sv
hw/icache_bank.sv
hw/icache_resp_queue.sv
hw/icache_top.sv
tests/tb_clock_gen.sv
tests/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - hw/icache_pkg.sv
  - hw/icache_lookup_if.sv
  - hw/icache_fetch_decode.sv
  - hw/icache_bank.sv
  - hw/icache_resp_queue.sv
  - hw/icache_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/icache_tb.sv
